// ==== include/axi2lite_defines.svh ====
`ifndef AXI2LITE_DEFINES_SVH
`define AXI2LITE_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// AXI field widths
////////////////////////////////////////////////////////////////////////////

// Transaction ID
`define AXI_ID_W	2

// Byte address on both sides of the bridge
`define AXI_ADDR_W	8

// Data bus, same on AXI and AXI-Lite
`define AXI_DATA_W	32

// ARLEN, beats minus one
`define AXI_LEN_W	8

// ARSIZE, log2 of bytes per beat
`define AXI_SIZE_W	3

// Log2 of the number of bursts that may be outstanding
`define TRK_LGDEPTH	4

`endif

// ==== design/axi2lite_pkg.sv ====
`include "axi2lite_defines.svh"

package axi2lite_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// ARBURST, 2'b11 is reserved
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} axi_burst_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// Splitter FSM
	typedef enum logic {
		SPLIT_IDLE  = 1'b0,
		SPLIT_ISSUE = 1'b1
	} split_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Channel payloads
	////////////////////////////////////////////////////////////////////////////

	// AXI read request
	typedef struct packed {
		logic [`AXI_ID_W-1:0]   id;
		logic [`AXI_ADDR_W-1:0] addr;
		logic [`AXI_LEN_W-1:0]  len;
		logic [`AXI_SIZE_W-1:0] size;
		axi_burst_e             burst;
	} ar_req_t;

	// One entry per outstanding burst
	typedef struct packed {
		logic [`AXI_ID_W-1:0]  id;
		logic [`AXI_LEN_W-1:0] len;
	} burst_desc_t;

	// AXI-Lite read data
	typedef struct packed {
		logic [`AXI_DATA_W-1:0] data;
		axi_resp_e              resp;
	} lite_rbeat_t;

	// AXI read data beat
	typedef struct packed {
		logic [`AXI_ID_W-1:0]   id;
		logic [`AXI_DATA_W-1:0] data;
		axi_resp_e              resp;
		logic                   last;
	} axi_rbeat_t;

endpackage

// ==== design/burst_splitter.sv ====
`timescale 1ns/1ps
`include "axi2lite_defines.svh"

module burst_splitter (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// AXI read request
	input  logic                    i_s_arvalid,
	output logic                    o_s_arready,
	input  axi2lite_pkg::ar_req_t   i_s_ar,
	// Burst tracker
	input  logic                    i_trk_full,
	output logic                    o_trk_push,
	output axi2lite_pkg::burst_desc_t o_trk_desc,
	// AXI-Lite read address
	output logic [`AXI_ADDR_W-1:0]  o_m_araddr,
	output logic                    o_m_arvalid,
	input  logic                    i_m_arready
);

	import axi2lite_pkg::*;

	localparam int AW = `AXI_ADDR_W;
	// Wide enough for 256 beats of 128 bytes
	localparam int WIN_W = `AXI_LEN_W + (1 << `AXI_SIZE_W);

	split_state_e           state;
	logic [AW-1:0]          addr_q;
	logic [`AXI_LEN_W-1:0]  len_q;
	logic [`AXI_LEN_W-1:0]  beats_left;
	logic [`AXI_SIZE_W-1:0] size_q;
	axi_burst_e             burst_q;

	logic                   accept;
	logic                   addr_xfer;
	logic                   final_xfer;
	logic [AW-1:0]          step;
	logic [AW-1:0]          incr_addr;
	logic [AW-1:0]          wrap_mask;
	logic [WIN_W-1:0]       win_bytes;
	logic [AW-1:0]          next_addr;

	////////////////////////////////////////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////////////////////////////////////////

	assign o_m_arvalid = (state == SPLIT_ISSUE);
	assign o_m_araddr  = addr_q;
	assign addr_xfer   = o_m_arvalid && i_m_arready;
	assign final_xfer  = addr_xfer && (beats_left == '0);

	// Take a new burst while the last address of the old one goes out
	assign o_s_arready = ((state == SPLIT_IDLE) || final_xfer) && !i_trk_full;
	assign accept      = i_s_arvalid && o_s_arready;

	assign o_trk_push     = accept;
	assign o_trk_desc.id  = i_s_ar.id;
	assign o_trk_desc.len = i_s_ar.len;

	////////////////////////////////////////////////////////////////////////////
	// Next beat address
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		step      = AW'(1) << size_q;
		incr_addr = addr_q + step;
		// Wrap window is (len+1) beats, aligned to its own size
		win_bytes = (WIN_W'(len_q) + WIN_W'(1)) << size_q;
		wrap_mask = AW'(win_bytes - WIN_W'(1));

		case (burst_q)
		BURST_FIXED:
			next_addr = addr_q;
		BURST_WRAP:
			next_addr = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);
		default:
			// Reserved encoding steps like INCR
			next_addr = incr_addr;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// FSM and beat counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state      <= SPLIT_IDLE;
			beats_left <= '0;
		end
		else if (accept)
		begin
			state      <= SPLIT_ISSUE;
			beats_left <= i_s_ar.len;
		end
		else if (final_xfer)
			state <= SPLIT_IDLE;
		else if (addr_xfer)
			beats_left <= beats_left - 1'b1;
	end

	// Request fields, held for the length of the burst
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
		begin
			addr_q  <= i_s_ar.addr;
			len_q   <= i_s_ar.len;
			size_q  <= i_s_ar.size;
			burst_q <= i_s_ar.burst;
		end
		else if (addr_xfer)
			addr_q <= next_addr;
	end

endmodule

// ==== design/burst_tracker_fifo.sv ====
`timescale 1ns/1ps
`include "axi2lite_defines.svh"

module burst_tracker_fifo #(
	parameter int LGDEPTH = `TRK_LGDEPTH
) (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_push,
	input  axi2lite_pkg::burst_desc_t i_desc,
	input  logic                      i_pop,
	output axi2lite_pkg::burst_desc_t o_head,
	output logic                      o_empty,
	output logic                      o_full
);

	import axi2lite_pkg::*;

	localparam int DEPTH = 1 << LGDEPTH;

	burst_desc_t        mem [DEPTH];
	logic [LGDEPTH-1:0] wr_ptr;
	logic [LGDEPTH-1:0] rd_ptr;
	logic [LGDEPTH:0]   count;

	logic               do_push;
	logic               do_pop;

	assign o_empty = (count == '0);
	assign o_full  = (count == (LGDEPTH+1)'(DEPTH));

	// Requests against a full or empty queue are dropped
	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	// Oldest burst, read straight from the array
	assign o_head = mem[rd_ptr];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_push)
			mem[wr_ptr] <= i_desc;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_push, do_pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

endmodule

// ==== design/read_return.sv ====
`timescale 1ns/1ps
`include "axi2lite_defines.svh"

module read_return (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	// AXI-Lite read data
	input  logic                      i_m_rvalid,
	output logic                      o_m_rready,
	input  axi2lite_pkg::lite_rbeat_t i_m_r,
	// Burst tracker
	input  axi2lite_pkg::burst_desc_t i_trk_head,
	input  logic                      i_trk_empty,
	output logic                      o_trk_pop,
	// AXI read data
	output logic                      o_s_rvalid,
	input  logic                      i_s_rready,
	output axi2lite_pkg::axi_rbeat_t  o_s_r
);

	import axi2lite_pkg::*;

	// Beats still owed for the burst in progress, zero between bursts
	logic [`AXI_LEN_W-1:0] beats_left;
	logic [`AXI_ID_W-1:0]  burst_id;

	logic                  first_beat;
	logic                  beat_xfer;
	logic                  out_free;
	logic                  beat_last;
	logic [`AXI_ID_W-1:0]  beat_id;

	////////////////////////////////////////////////////////////////////////////
	// Lite side acceptance
	////////////////////////////////////////////////////////////////////////////

	assign first_beat = (beats_left == '0);
	assign out_free   = !o_s_rvalid || i_s_rready;

	// A new burst needs its descriptor at the head
	assign o_m_rready = out_free && (!first_beat || !i_trk_empty);
	assign beat_xfer  = i_m_rvalid && o_m_rready;
	assign o_trk_pop  = beat_xfer && first_beat;

	always_comb
	begin
		if (first_beat)
		begin
			beat_id   = i_trk_head.id;
			beat_last = (i_trk_head.len == '0);
		end
		else
		begin
			beat_id   = burst_id;
			beat_last = (beats_left == `AXI_LEN_W'(1));
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			beats_left <= '0;
		else if (beat_xfer)
		begin
			if (first_beat)
				beats_left <= i_trk_head.len;
			else
				beats_left <= beats_left - 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_trk_pop)
			burst_id <= i_trk_head.id;
	end

	////////////////////////////////////////////////////////////////////////////
	// AXI beat register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_s_rvalid <= 1'b0;
		else if (beat_xfer)
			o_s_rvalid <= 1'b1;
		else if (i_s_rready)
			o_s_rvalid <= 1'b0;
	end

	// Response passes through as the slave gave it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (beat_xfer)
		begin
			o_s_r.id   <= beat_id;
			o_s_r.data <= i_m_r.data;
			o_s_r.resp <= i_m_r.resp;
			o_s_r.last <= beat_last;
		end
	end

endmodule

// ==== design/axi2lite_read_bridge.sv ====
`timescale 1ns/1ps
`include "axi2lite_defines.svh"

module axi2lite_read_bridge (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	// AXI slave, read address
	input  logic                      S_AXI_ARVALID,
	output logic                      S_AXI_ARREADY,
	input  axi2lite_pkg::ar_req_t     i_s_ar,
	// AXI slave, read data
	output logic                      S_AXI_RVALID,
	input  logic                      S_AXI_RREADY,
	output axi2lite_pkg::axi_rbeat_t  o_s_r,
	// AXI-Lite master, read address
	output logic [`AXI_ADDR_W-1:0]    o_m_araddr,
	output logic [2:0]                o_m_arprot,
	output logic                      o_m_arvalid,
	input  logic                      i_m_arready,
	// AXI-Lite master, read data
	input  logic                      i_m_rvalid,
	output logic                      o_m_rready,
	input  axi2lite_pkg::lite_rbeat_t i_m_r
);

	import axi2lite_pkg::*;

	logic        trk_push;
	logic        trk_pop;
	logic        trk_empty;
	logic        trk_full;
	burst_desc_t trk_desc;
	burst_desc_t trk_head;

	// Unprivileged, secure, data access
	assign o_m_arprot = 3'b000;

	////////////////////////////////////////////////////////////////////////////
	// Request path
	////////////////////////////////////////////////////////////////////////////

	burst_splitter u_splitter (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_s_arvalid   (S_AXI_ARVALID),
		.o_s_arready   (S_AXI_ARREADY),
		.i_s_ar        (i_s_ar),
		.i_trk_full    (trk_full),
		.o_trk_push    (trk_push),
		.o_trk_desc    (trk_desc),
		.o_m_araddr    (o_m_araddr),
		.o_m_arvalid   (o_m_arvalid),
		.i_m_arready   (i_m_arready)
	);

	// ID and length of every burst in flight
	burst_tracker_fifo #(
		.LGDEPTH (`TRK_LGDEPTH)
	) u_tracker (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_push        (trk_push),
		.i_desc        (trk_desc),
		.i_pop         (trk_pop),
		.o_head        (trk_head),
		.o_empty       (trk_empty),
		.o_full        (trk_full)
	);

	////////////////////////////////////////////////////////////////////////////
	// Response path
	////////////////////////////////////////////////////////////////////////////

	read_return u_return (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_m_rvalid    (i_m_rvalid),
		.o_m_rready    (o_m_rready),
		.i_m_r         (i_m_r),
		.i_trk_head    (trk_head),
		.i_trk_empty   (trk_empty),
		.o_trk_pop     (trk_pop),
		.o_s_rvalid    (S_AXI_RVALID),
		.i_s_rready    (S_AXI_RREADY),
		.o_s_r         (o_s_r)
	);

endmodule

// ==== verification/axil_mem_model.sv ====
`timescale 1ns/1ps
`include "axi2lite_defines.svh"

module axil_mem_model (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic [`AXI_ADDR_W-1:0]    i_araddr,
	input  logic                      i_arvalid,
	output logic                      o_arready,
	output logic                      o_rvalid,
	input  logic                      i_rready,
	output axi2lite_pkg::lite_rbeat_t o_r
);

	import axi2lite_pkg::*;

	// Chance in percent of holding ready or valid low for a cycle
	localparam int AR_STALL_PCT = 25;
	localparam int R_STALL_PCT  = 35;

	logic [`AXI_ADDR_W-1:0] pending [$];
	logic                   in_reset;
	logic                   r_done;

	// Top quarter of the address map answers SLVERR
	function automatic lite_rbeat_t read_word(input logic [`AXI_ADDR_W-1:0] addr);
		lite_rbeat_t word;
		word.data = {{(`AXI_DATA_W-`AXI_ADDR_W){1'b0}}, addr} ^ 32'h5A5A0000;
		word.resp = (addr[`AXI_ADDR_W-1] && addr[`AXI_ADDR_W-2]) ? RESP_SLVERR : RESP_OKAY;
		return word;
	endfunction

	initial
	begin
		o_arready = 1'b0;
		o_rvalid  = 1'b0;
		o_r       = '0;
		forever
		begin
			@(posedge S_AXI_ACLK);
			in_reset = !S_AXI_ARESETN;
			r_done   = o_rvalid && i_rready;
			if (in_reset)
				pending.delete();
			else
			begin
				if (r_done)
					void'(pending.pop_front());
				if (i_arvalid && o_arready)
					pending.push_back(i_araddr);
			end
			#1;
			o_arready = !in_reset && ($urandom_range(99) >= AR_STALL_PCT);
			// A beat on offer stays until it is taken
			if (in_reset)
				o_rvalid = 1'b0;
			else if (!o_rvalid || r_done)
			begin
				o_rvalid = (pending.size() != 0) && ($urandom_range(99) >= R_STALL_PCT);
				if (o_rvalid)
					o_r = read_word(pending[0]);
			end
		end
	end

endmodule

// ==== verification/tb_axi2lite_read.sv ====
`timescale 1ns/1ps
`include "axi2lite_defines.svh"

module tb_axi2lite_read;

	import axi2lite_pkg::*;

	localparam int AW            = `AXI_ADDR_W;
	localparam int SEED          = 55788;
	localparam int AR_TIMEOUT    = 200;
	localparam int DRAIN_TIMEOUT = 5000;

	logic          S_AXI_ACLK = 1'b0;
	logic          S_AXI_ARESETN;
	logic          S_AXI_ARVALID;
	logic          S_AXI_ARREADY;
	ar_req_t       s_ar;
	logic          S_AXI_RVALID;
	logic          S_AXI_RREADY;
	axi_rbeat_t    s_r;
	logic [AW-1:0] m_araddr;
	logic [2:0]    m_arprot;
	logic          m_arvalid;
	logic          m_arready;
	logic          m_rvalid;
	logic          m_rready;
	lite_rbeat_t   m_r;

	logic          rready_random;
	logic          rready_toggle;
	int            mismatch_count = 0;
	int            beat_errors    = 0;
	int            run_errors     = 0;
	int            beats_checked  = 0;

	axi_rbeat_t    exp_beats [$];
	logic [AW-1:0] exp_addrs [$];
	logic [AW-1:0] seen_addrs [$];
	axi_rbeat_t    cmp_beat;
	logic [AW-1:0] cmp_addr;

	always #2 S_AXI_ACLK = ~S_AXI_ACLK;

	axi2lite_read_bridge dut0 (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.i_s_ar        (s_ar),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.o_s_r         (s_r),
		.o_m_araddr    (m_araddr),
		.o_m_arprot    (m_arprot),
		.o_m_arvalid   (m_arvalid),
		.i_m_arready   (m_arready),
		.i_m_rvalid    (m_rvalid),
		.o_m_rready    (m_rready),
		.i_m_r         (m_r)
	);

	axil_mem_model u_mem (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_araddr      (m_araddr),
		.i_arvalid     (m_arvalid),
		.o_arready     (m_arready),
		.o_rvalid      (m_rvalid),
		.i_rready      (m_rready),
		.o_r           (m_r)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Address of beat n under the AXI burst rules
	function automatic logic [AW-1:0] beat_addr(input ar_req_t req, input int n);
		int step;
		int start;
		int win;
		int base;
		step  = 1 << req.size;
		start = int'(req.addr);
		win   = (int'(req.len) + 1) * step;
		base  = start - (start % win);
		case (req.burst)
		BURST_FIXED:
			return req.addr;
		BURST_WRAP:
			return AW'(base + (start - base + n * step) % win);
		default:
			return AW'(start + n * step);
		endcase
	endfunction

	function automatic void expected_beats(input ar_req_t req);
		axi_rbeat_t    beat;
		logic [AW-1:0] addr;
		for (int n = 0; n <= int'(req.len); n++)
		begin
			addr      = beat_addr(req, n);
			beat.id   = req.id;
			beat.data = {24'h0, addr} ^ 32'h5A5A0000;
			beat.resp = (addr >= 8'hC0) ? RESP_SLVERR : RESP_OKAY;
			beat.last = (n == int'(req.len));
			exp_addrs.push_back(addr);
			exp_beats.push_back(beat);
		end
	endfunction

	task automatic check_rbeat(input axi_rbeat_t got, input axi_rbeat_t want);
		if (got !== want)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: o_s_r got %h expected %h", $time, got, want);
		end
	endtask

	task automatic check_addr(input logic [AW-1:0] got, input logic [AW-1:0] want);
		if (got !== want)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: o_m_araddr got %h expected %h", $time, got, want);
		end
	endtask

	task automatic check_prot(input logic [2:0] got, input logic [2:0] want);
		if (got !== want)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: o_m_arprot got %h expected %h", $time, got, want);
		end
	endtask

	task automatic finish_run();
		$display("Beats checked %0d, mismatches %0d, beat errors %0d, run errors %0d",
			beats_checked, mismatch_count, beat_errors, run_errors);
		if (mismatch_count == 0 && beat_errors == 0 && run_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic issue_ar(
		input logic [`AXI_ID_W-1:0]   id,
		input logic [AW-1:0]          addr,
		input logic [`AXI_LEN_W-1:0]  len,
		input logic [`AXI_SIZE_W-1:0] size,
		input axi_burst_e             burst
	);
		ar_req_t req;
		int      waited;
		logic    accepted;
		req.id        = id;
		req.addr      = addr;
		req.len       = len;
		req.size      = size;
		req.burst     = burst;
		s_ar          = req;
		S_AXI_ARVALID = 1'b1;
		waited        = 0;
		accepted      = 1'b0;
		while (!accepted && waited < AR_TIMEOUT)
		begin
			@(posedge S_AXI_ACLK);
			accepted = S_AXI_ARREADY;
			waited++;
		end
		#1;
		S_AXI_ARVALID = 1'b0;
		if (accepted)
			expected_beats(req);
		else
		begin
			run_errors++;
			$display("Error at %0t: AR for id %0h was never accepted", $time, id);
			finish_run();
		end
	endtask

	task automatic issue_random_ar(input logic [`AXI_ID_W-1:0] id);
		logic [`AXI_LEN_W-1:0]  len;
		logic [`AXI_SIZE_W-1:0] size;
		logic [AW-1:0]          addr;
		axi_burst_e             burst;
		size = `AXI_SIZE_W'($urandom_range(2));
		addr = AW'($urandom_range(255)) & ~((AW'(1) << size) - AW'(1));
		if ($urandom_range(1) != 0)
		begin
			burst = BURST_WRAP;
			len   = `AXI_LEN_W'((2 << $urandom_range(2)) - 1);
		end
		else
		begin
			burst = BURST_INCR;
			len   = `AXI_LEN_W'($urandom_range(7));
		end
		issue_ar(id, addr, len, size, burst);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_beats.size() != 0 && waited < DRAIN_TIMEOUT)
		begin
			@(posedge S_AXI_ACLK);
			#1;
			waited++;
		end
		if (exp_beats.size() != 0)
		begin
			run_errors++;
			$display("Error at %0t: %0d read beats never arrived", $time, exp_beats.size());
			finish_run();
		end
	endtask

	// R back-pressure, sampled at the edge and applied just after it
	initial
	begin
		S_AXI_RREADY = 1'b1;
		forever
		begin
			@(posedge S_AXI_ACLK);
			rready_toggle = rready_random;
			#1;
			S_AXI_RREADY = !rready_toggle || ($urandom_range(1) != 0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitor and comparison
	////////////////////////////////////////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN && m_arvalid && m_arready)
		begin
			seen_addrs.push_back(m_araddr);
			// Every Lite read is an unprivileged, secure data access
			check_prot(m_arprot, 3'b000);
		end
	end

	always @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN && S_AXI_RVALID && S_AXI_RREADY)
		begin
			if (exp_beats.size() == 0)
			begin
				beat_errors++;
				$display("Error at %0t: beat with id %0h arrived with no burst outstanding",
					$time, s_r.id);
			end
			else
			begin
				cmp_beat = exp_beats.pop_front();
				cmp_addr = exp_addrs.pop_front();
				check_rbeat(s_r, cmp_beat);
				if (seen_addrs.size() == 0)
				begin
					beat_errors++;
					$display("Error at %0t: beat returned before its Lite address", $time);
				end
				else
					check_addr(seen_addrs.pop_front(), cmp_addr);
				beats_checked++;
			end
		end
	end

	initial
	begin
		void'($urandom(SEED));
		S_AXI_ARESETN = 1'b0;
		S_AXI_ARVALID = 1'b0;
		s_ar          = '0;
		rready_random = 1'b0;
		repeat (8)
			@(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		// Single beat, then plain INCR bursts
		issue_ar(2'd1, 8'h10, 8'd0, 3'd2, BURST_INCR);
		wait_drain();
		issue_ar(2'd2, 8'h20, 8'd5, 3'd2, BURST_INCR);
		issue_ar(2'd3, 8'h41, 8'd3, 3'd0, BURST_INCR);
		wait_drain();

		// Wrap windows of 4 and 8 beats, and a FIXED burst
		issue_ar(2'd0, 8'h38, 8'd3, 3'd2, BURST_WRAP);
		issue_ar(2'd1, 8'h54, 8'd7, 3'd2, BURST_WRAP);
		issue_ar(2'd2, 8'h66, 8'd3, 3'd1, BURST_WRAP);
		issue_ar(2'd3, 8'h7C, 8'd4, 3'd2, BURST_FIXED);
		wait_drain();

		// Crosses into the SLVERR region at 0xC0
		issue_ar(2'd2, 8'hB8, 8'd7, 3'd2, BURST_INCR);
		wait_drain();

		rready_random = 1'b1;
		for (int n = 0; n < 24; n++)
			issue_random_ar(2'(n));
		wait_drain();
		rready_random = 1'b0;

		// Quiet period to catch stray addresses
		repeat (20)
			@(posedge S_AXI_ACLK);
		if (seen_addrs.size() != 0)
		begin
			run_errors++;
			$display("Error: %0d Lite addresses were issued without a matching beat",
				seen_addrs.size());
		end
		finish_run();
	end

endmodule

// ==== project.f ====
+incdir+include
design/axi2lite_pkg.sv
design/burst_splitter.sv
design/burst_tracker_fifo.sv
design/read_return.sv
design/axi2lite_read_bridge.sv
verification/axil_mem_model.sv
verification/tb_axi2lite_read.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI4 to AXI4-Lite read bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"

verilator --binary --timing -j 0 \
	--top-module tb_axi2lite_read \
	-f project.f \
	-o sim_axi2lite
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_axi2lite > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
	exit 1
fi
exit 0
